//--- verilog/io_overlay_pkg.sv
/* Shared constants for the board I/O overlay: pad counts, pad positions
   and the core-side tie-off pattern used while the JTAG overlay is active */

package io_overlay_pkg;

  ////////////////////
  // Pad counts
  ////////////////////

  parameter int NumMio = 16; // Muxed pads
  parameter int NumDio = 10; // Dedicated pads

  ////////////////////
  // Dedicated pads
  ////////////////////

  // USB device lines
  parameter int DioUsbDn       = 0;
  parameter int DioUsbDp       = 1;
  parameter int DioUsbD        = 2; // Single-ended receive data
  parameter int DioUsbSense    = 3; // VBUS sense
  parameter int DioUsbDnPullup = 4; // Its enable also marks a pin flip
  parameter int DioUsbDpPullup = 5;

  // SPI device lines, shared with JTAG when the overlay is on
  parameter int DioSpiSd1      = 6; // JTAG TDO
  parameter int DioSpiSd0      = 7; // JTAG TDI
  parameter int DioSpiCsb      = 8; // JTAG TMS
  parameter int DioSpiSck      = 9; // JTAG TCK

  ////////////////////
  // Muxed pads
  ////////////////////

  parameter int MioUphySel  = 2;  // Strap for the external USB PHY
  parameter int MioJtagEn   = 12; // Strap for the JTAG overlay
  parameter int MioJtagTrst = 13;
  parameter int MioJtagSrst = 14;

  ////////////////////
  // JTAG tie-off
  ////////////////////

  // Values the core reads on the borrowed dedicated pads
  // Chip select idles high so the SPI device stays deselected
  parameter logic [NumDio-1:0] JtagTieOff = NumDio'(1 << DioSpiCsb);

endpackage

//--- verilog/pad_in_sync.sv
/* Brings the asynchronous pad inputs and external USB PHY receive lines
   into the main clock domain through a flop chain of configurable depth */

`timescale 1ns/1ps

module pad_in_sync #(
  parameter int SyncStages = 2
) (
  input  logic                              clk_main_i,
  input  logic                              arst_n_i,
  input  logic [io_overlay_pkg::NumMio-1:0] mio_pad_in_i,
  input  logic [io_overlay_pkg::NumDio-1:0] dio_pad_in_i,
  input  logic                              uphy_dp_rx_i,
  input  logic                              uphy_dn_rx_i,
  input  logic                              uphy_d_rx_i,
  input  logic                              uphy_sense_i,
  output logic [io_overlay_pkg::NumMio-1:0] mio_sync_o,
  output logic [io_overlay_pkg::NumDio-1:0] dio_sync_o,
  output logic                              uphy_dp_sync_o,
  output logic                              uphy_dn_sync_o,
  output logic                              uphy_d_sync_o,
  output logic                              uphy_sense_sync_o
);

  // Pads plus the four PHY lines
  localparam int SyncWidth = io_overlay_pkg::NumMio + io_overlay_pkg::NumDio + 4;

  logic [SyncWidth-1:0] sync_in;
  logic [SyncStages-1:0][SyncWidth-1:0] sync_q;

  // PHY lines on top, muxed pads at the bottom
  assign sync_in = {uphy_sense_i, uphy_d_rx_i, uphy_dn_rx_i, uphy_dp_rx_i,
                    dio_pad_in_i, mio_pad_in_i};

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= sync_in;
      for (int i = 1; i < SyncStages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Last stage splits back into the separate lines
  assign {uphy_sense_sync_o, uphy_d_sync_o, uphy_dn_sync_o, uphy_dp_sync_o,
          dio_sync_o, mio_sync_o} = sync_q[SyncStages-1];

endmodule

//--- verilog/jtag_overlay_mux.sv
/* JTAG overlay between the synchronized pads and the core side. A strap pad
   lends the SPI device pads and two muxed pads to the JTAG port; all other
   pads pass straight through */

`timescale 1ns/1ps

module jtag_overlay_mux #(
  parameter bit JtagEnPolarity = 1'b1
) (
  // Pad side, already synchronized
  input  logic [io_overlay_pkg::NumMio-1:0] mio_pad_in_i,
  input  logic [io_overlay_pkg::NumDio-1:0] dio_pad_in_i,
  output logic [io_overlay_pkg::NumMio-1:0] mio_pad_out_o,
  output logic [io_overlay_pkg::NumMio-1:0] mio_pad_oe_o,
  output logic [io_overlay_pkg::NumDio-1:0] dio_pad_out_o,
  output logic [io_overlay_pkg::NumDio-1:0] dio_pad_oe_o,
  // Core side, dedicated pads via the USB mux
  input  logic [io_overlay_pkg::NumMio-1:0] mio_core_out_i,
  input  logic [io_overlay_pkg::NumMio-1:0] mio_core_oe_i,
  input  logic [io_overlay_pkg::NumDio-1:0] dio_umux_out_i,
  input  logic [io_overlay_pkg::NumDio-1:0] dio_umux_oe_i,
  output logic [io_overlay_pkg::NumMio-1:0] mio_core_in_o,
  output logic [io_overlay_pkg::NumDio-1:0] dio_umux_in_o,
  // JTAG port
  input  logic                              jtag_tdo_i,
  output logic                              jtag_tck_o,
  output logic                              jtag_tms_o,
  output logic                              jtag_tdi_o,
  output logic                              jtag_trst_n_o,
  output logic                              jtag_srst_n_o
);

  ////////////////////
  // Overlay masks
  ////////////////////

  // Dedicated pads taken over by JTAG
  localparam logic [io_overlay_pkg::NumDio-1:0] DioMask =
      io_overlay_pkg::NumDio'((1 << io_overlay_pkg::DioSpiSck) |
                              (1 << io_overlay_pkg::DioSpiCsb) |
                              (1 << io_overlay_pkg::DioSpiSd0) |
                              (1 << io_overlay_pkg::DioSpiSd1));

  // Muxed pads carrying the two resets
  localparam logic [io_overlay_pkg::NumMio-1:0] MioMask =
      io_overlay_pkg::NumMio'((1 << io_overlay_pkg::MioJtagTrst) |
                              (1 << io_overlay_pkg::MioJtagSrst));

  logic jtag_en;

  // Strap pad is never overlaid itself
  assign jtag_en = (mio_pad_in_i[io_overlay_pkg::MioJtagEn] == JtagEnPolarity);

  ////////////////////
  // Routing
  ////////////////////

  always_comb begin
    // Inactive overlay passes everything through
    mio_core_in_o = mio_pad_in_i;
    dio_umux_in_o = dio_pad_in_i;
    mio_pad_out_o = mio_core_out_i;
    mio_pad_oe_o  = mio_core_oe_i;
    dio_pad_out_o = dio_umux_out_i;
    dio_pad_oe_o  = dio_umux_oe_i;

    // Idle JTAG levels, TAP held in reset
    jtag_tck_o    = 1'b0;
    jtag_tms_o    = 1'b1;
    jtag_tdi_o    = 1'b0;
    jtag_trst_n_o = 1'b0;
    jtag_srst_n_o = 1'b1;

    if (jtag_en) begin
      // Core sees tie-offs on the borrowed pads
      mio_core_in_o = mio_pad_in_i & ~MioMask;
      dio_umux_in_o = (dio_pad_in_i & ~DioMask) | (io_overlay_pkg::JtagTieOff & DioMask);

      // Borrowed pads are not driven by the core
      mio_pad_out_o = mio_core_out_i & ~MioMask;
      mio_pad_oe_o  = mio_core_oe_i & ~MioMask;
      dio_pad_out_o = dio_umux_out_i & ~DioMask;
      dio_pad_oe_o  = dio_umux_oe_i & ~DioMask;

      // TDO is the only JTAG output
      dio_pad_out_o[io_overlay_pkg::DioSpiSd1] = jtag_tdo_i;
      dio_pad_oe_o[io_overlay_pkg::DioSpiSd1]  = 1'b1;

      jtag_tck_o    = dio_pad_in_i[io_overlay_pkg::DioSpiSck];
      jtag_tms_o    = dio_pad_in_i[io_overlay_pkg::DioSpiCsb];
      jtag_tdi_o    = dio_pad_in_i[io_overlay_pkg::DioSpiSd0];
      jtag_trst_n_o = mio_pad_in_i[io_overlay_pkg::MioJtagTrst];
      jtag_srst_n_o = mio_pad_in_i[io_overlay_pkg::MioJtagSrst];
    end
  end

endmodule

//--- verilog/usb_pinflip_mux.sv
/* Undoes the core's USB D+/D- pin flip so the board always sees unflipped
   lines, and selects receive data from an external USB PHY when strapped */

`timescale 1ns/1ps

module usb_pinflip_mux (
  // Core side
  input  logic [io_overlay_pkg::NumDio-1:0] dio_core_out_i,
  input  logic [io_overlay_pkg::NumDio-1:0] dio_core_oe_i,
  output logic [io_overlay_pkg::NumDio-1:0] dio_core_in_o,
  // Toward the JTAG overlay
  output logic [io_overlay_pkg::NumDio-1:0] dio_umux_out_o,
  output logic [io_overlay_pkg::NumDio-1:0] dio_umux_oe_o,
  input  logic [io_overlay_pkg::NumDio-1:0] dio_umux_in_i,
  // External PHY
  input  logic                              uphy_sel_i,
  input  logic                              uphy_dp_rx_i,
  input  logic                              uphy_dn_rx_i,
  input  logic                              uphy_d_rx_i,
  input  logic                              uphy_sense_i,
  output logic                              uphy_dp_tx_o,
  output logic                              uphy_dn_tx_o,
  output logic                              uphy_oe_n_o,
  output logic                              uphy_dppullup_o
);

  logic undo_swap;
  logic rx_dp, rx_dn, rx_d, rx_sense;

  // Core flags a flip through the Dn pullup enable
  assign undo_swap = dio_core_oe_i[io_overlay_pkg::DioUsbDnPullup];

  ////////////////////
  // Receive source
  ////////////////////

  assign rx_dp    = uphy_sel_i ? uphy_dp_rx_i : dio_umux_in_i[io_overlay_pkg::DioUsbDp];
  assign rx_dn    = uphy_sel_i ? uphy_dn_rx_i : dio_umux_in_i[io_overlay_pkg::DioUsbDn];
  assign rx_d     = uphy_sel_i ? uphy_d_rx_i  : dio_umux_in_i[io_overlay_pkg::DioUsbD];
  assign rx_sense = uphy_sel_i ? uphy_sense_i : dio_umux_in_i[io_overlay_pkg::DioUsbSense];

  ////////////////////
  // Flip undo
  ////////////////////

  always_comb begin
    // Non-USB pads pass through
    dio_umux_out_o = dio_core_out_i;
    dio_umux_oe_o  = dio_core_oe_i;
    dio_core_in_o  = dio_umux_in_i;

    dio_core_in_o[io_overlay_pkg::DioUsbDp]    = rx_dp;
    dio_core_in_o[io_overlay_pkg::DioUsbDn]    = rx_dn;
    dio_core_in_o[io_overlay_pkg::DioUsbD]     = rx_d;
    dio_core_in_o[io_overlay_pkg::DioUsbSense] = rx_sense;

    if (undo_swap) begin
      // Differential pair, all three directions
      dio_umux_out_o[io_overlay_pkg::DioUsbDn] = dio_core_out_i[io_overlay_pkg::DioUsbDp];
      dio_umux_out_o[io_overlay_pkg::DioUsbDp] = dio_core_out_i[io_overlay_pkg::DioUsbDn];
      dio_umux_oe_o[io_overlay_pkg::DioUsbDn]  = dio_core_oe_i[io_overlay_pkg::DioUsbDp];
      dio_umux_oe_o[io_overlay_pkg::DioUsbDp]  = dio_core_oe_i[io_overlay_pkg::DioUsbDn];
      dio_core_in_o[io_overlay_pkg::DioUsbDn]  = rx_dp;
      dio_core_in_o[io_overlay_pkg::DioUsbDp]  = rx_dn;

      // Single-ended D flips polarity, enable untouched
      dio_umux_out_o[io_overlay_pkg::DioUsbD] = ~dio_core_out_i[io_overlay_pkg::DioUsbD];
      dio_core_in_o[io_overlay_pkg::DioUsbD]  = ~rx_d;

      // Pullups swap on the output side only
      dio_umux_out_o[io_overlay_pkg::DioUsbDnPullup] =
          dio_core_out_i[io_overlay_pkg::DioUsbDpPullup];
      dio_umux_out_o[io_overlay_pkg::DioUsbDpPullup] =
          dio_core_out_i[io_overlay_pkg::DioUsbDnPullup];
      dio_umux_oe_o[io_overlay_pkg::DioUsbDnPullup] =
          dio_core_oe_i[io_overlay_pkg::DioUsbDpPullup];
      dio_umux_oe_o[io_overlay_pkg::DioUsbDpPullup] =
          dio_core_oe_i[io_overlay_pkg::DioUsbDnPullup];
    end
  end

  ////////////////////
  // PHY outputs
  ////////////////////

  // Always driven from the remapped lines
  assign uphy_dp_tx_o    = dio_umux_out_o[io_overlay_pkg::DioUsbDp];
  assign uphy_dn_tx_o    = dio_umux_out_o[io_overlay_pkg::DioUsbDn];
  assign uphy_oe_n_o     = ~dio_umux_oe_o[io_overlay_pkg::DioUsbDp]; // Active low
  assign uphy_dppullup_o = dio_umux_out_o[io_overlay_pkg::DioUsbDpPullup] &
                           dio_umux_oe_o[io_overlay_pkg::DioUsbDpPullup];

endmodule

//--- verilog/io_overlay_top.sv
/* Pad-side I/O routing of the board wrapper. Pad inputs are synchronized, then
   pass the JTAG overlay and the USB pin-flip mux on their way to the core;
   core outputs take the reverse path to the pads and the external USB PHY */

`timescale 1ns/1ps

module io_overlay_top #(
  parameter int SyncStages     = 2,
  parameter bit JtagEnPolarity = 1'b1
) (
  input  logic                              clk_main_i,
  input  logic                              arst_n_i,
  // Pads
  input  logic [io_overlay_pkg::NumMio-1:0] mio_pad_in_i,
  input  logic [io_overlay_pkg::NumDio-1:0] dio_pad_in_i,
  output logic [io_overlay_pkg::NumMio-1:0] mio_pad_out_o,
  output logic [io_overlay_pkg::NumMio-1:0] mio_pad_oe_o,
  output logic [io_overlay_pkg::NumDio-1:0] dio_pad_out_o,
  output logic [io_overlay_pkg::NumDio-1:0] dio_pad_oe_o,
  // Core
  input  logic [io_overlay_pkg::NumMio-1:0] mio_core_out_i,
  input  logic [io_overlay_pkg::NumMio-1:0] mio_core_oe_i,
  input  logic [io_overlay_pkg::NumDio-1:0] dio_core_out_i,
  input  logic [io_overlay_pkg::NumDio-1:0] dio_core_oe_i,
  output logic [io_overlay_pkg::NumMio-1:0] mio_core_in_o,
  output logic [io_overlay_pkg::NumDio-1:0] dio_core_in_o,
  // JTAG port
  input  logic                              jtag_tdo_i,
  output logic                              jtag_tck_o,
  output logic                              jtag_tms_o,
  output logic                              jtag_tdi_o,
  output logic                              jtag_trst_n_o,
  output logic                              jtag_srst_n_o,
  // External USB PHY
  input  logic                              uphy_dp_rx_i,
  input  logic                              uphy_dn_rx_i,
  input  logic                              uphy_d_rx_i,
  input  logic                              uphy_sense_i,
  output logic                              uphy_dp_tx_o,
  output logic                              uphy_dn_tx_o,
  output logic                              uphy_oe_n_o,
  output logic                              uphy_dppullup_o
);

  logic [io_overlay_pkg::NumMio-1:0] mio_sync;
  logic [io_overlay_pkg::NumDio-1:0] dio_sync;
  logic uphy_dp_sync, uphy_dn_sync, uphy_d_sync, uphy_sense_sync;

  // Between the JTAG overlay and the USB mux
  logic [io_overlay_pkg::NumDio-1:0] dio_umux_out, dio_umux_oe, dio_umux_in;

  ////////////////////
  // Input sync
  ////////////////////

  pad_in_sync #(
    .SyncStages (SyncStages)
  ) i_pad_in_sync (
    .clk_main_i        (clk_main_i),
    .arst_n_i          (arst_n_i),
    .mio_pad_in_i      (mio_pad_in_i),
    .dio_pad_in_i      (dio_pad_in_i),
    .uphy_dp_rx_i      (uphy_dp_rx_i),
    .uphy_dn_rx_i      (uphy_dn_rx_i),
    .uphy_d_rx_i       (uphy_d_rx_i),
    .uphy_sense_i      (uphy_sense_i),
    .mio_sync_o        (mio_sync),
    .dio_sync_o        (dio_sync),
    .uphy_dp_sync_o    (uphy_dp_sync),
    .uphy_dn_sync_o    (uphy_dn_sync),
    .uphy_d_sync_o     (uphy_d_sync),
    .uphy_sense_sync_o (uphy_sense_sync)
  );

  ////////////////////
  // JTAG overlay
  ////////////////////

  jtag_overlay_mux #(
    .JtagEnPolarity (JtagEnPolarity)
  ) i_jtag_overlay_mux (
    .mio_pad_in_i   (mio_sync),
    .dio_pad_in_i   (dio_sync),
    .mio_pad_out_o  (mio_pad_out_o),
    .mio_pad_oe_o   (mio_pad_oe_o),
    .dio_pad_out_o  (dio_pad_out_o),
    .dio_pad_oe_o   (dio_pad_oe_o),
    .mio_core_out_i (mio_core_out_i),
    .mio_core_oe_i  (mio_core_oe_i),
    .dio_umux_out_i (dio_umux_out),
    .dio_umux_oe_i  (dio_umux_oe),
    .mio_core_in_o  (mio_core_in_o), // Muxed pads go straight to the core
    .dio_umux_in_o  (dio_umux_in),
    .jtag_tdo_i     (jtag_tdo_i),
    .jtag_tck_o     (jtag_tck_o),
    .jtag_tms_o     (jtag_tms_o),
    .jtag_tdi_o     (jtag_tdi_o),
    .jtag_trst_n_o  (jtag_trst_n_o),
    .jtag_srst_n_o  (jtag_srst_n_o)
  );

  ////////////////////
  // USB pin flip
  ////////////////////

  usb_pinflip_mux i_usb_pinflip_mux (
    .dio_core_out_i  (dio_core_out_i),
    .dio_core_oe_i   (dio_core_oe_i),
    .dio_core_in_o   (dio_core_in_o),
    .dio_umux_out_o  (dio_umux_out),
    .dio_umux_oe_o   (dio_umux_oe),
    .dio_umux_in_i   (dio_umux_in),
    .uphy_sel_i      (mio_sync[io_overlay_pkg::MioUphySel]), // Strap taken before the overlay
    .uphy_dp_rx_i    (uphy_dp_sync),
    .uphy_dn_rx_i    (uphy_dn_sync),
    .uphy_d_rx_i     (uphy_d_sync),
    .uphy_sense_i    (uphy_sense_sync),
    .uphy_dp_tx_o    (uphy_dp_tx_o),
    .uphy_dn_tx_o    (uphy_dn_tx_o),
    .uphy_oe_n_o     (uphy_oe_n_o),
    .uphy_dppullup_o (uphy_dppullup_o)
  );

endmodule

//--- include/io_overlay_tests.svh
/* Directed tests for the I/O overlay, included into the testbench module.
   Each task drives the DUT through one behavior and checks the response */

  // All inputs low, then let the synchronizer settle
  task automatic quiet_inputs();
    wait_edges(Fall, 1);
    mio_pad_in_i   = '0;
    dio_pad_in_i   = '0;
    mio_core_out_i = '0;
    mio_core_oe_i  = '0;
    dio_core_out_i = '0;
    dio_core_oe_i  = '0;
    jtag_tdo_i     = 1'b0;
    {uphy_dp_rx_i, uphy_dn_rx_i, uphy_d_rx_i, uphy_sense_i} = 4'h0;
    wait_edges(Rise, SyncStages + 1);
  endtask

  task automatic check_reset_view();
    compare("mio core in", 32'h0, 32'(mio_core_in_o));
    compare("dio core in", 32'h0, 32'(dio_core_in_o));
    compare("jtag idle", 32'b01001,
            32'({jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_trst_n_o, jtag_srst_n_o}));
    compare("mio pad out", 32'(mio_core_out_i), 32'(mio_pad_out_o));
    compare("mio pad oe", 32'(mio_core_oe_i), 32'(mio_pad_oe_o));
    compare("dio pad out", 32'(dio_core_out_i), 32'(dio_pad_out_o));
    compare("dio pad oe", 32'(dio_core_oe_i), 32'(dio_pad_oe_o));
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset_state();
    begin_test("reset_state");
    mio_core_out_i = rand_mio();
    mio_core_oe_i  = rand_mio();
    dio_core_out_i = rand_dio();
    dio_core_oe_i  = rand_dio() & ~FlipMask; // No pin flip
    wait_edges(Rise, ResetCycles);
    check_reset_view();
    wait_edges(Fall, 1);
    arst_n_i = 1'b1;
    wait_edges(Rise, 1); // Still inside the synchronizer delay
    check_reset_view();
    end_test();
  endtask

  task automatic test_pass_through();
    begin_test("pass_through");
    quiet_inputs();
    for (int i = 0; i < 4; i++) begin
      wait_edges(Fall, 1);
      mio_core_out_i = rand_mio();
      mio_core_oe_i  = rand_mio();
      dio_core_out_i = rand_dio();
      dio_core_oe_i  = rand_dio() & ~FlipMask;
      mio_pad_in_i   = rand_mio() & ~(JtagEnMask | UphyMask); // Both straps off
      dio_pad_in_i   = rand_dio();
      wait_edges(Rise, 1);
      compare("mio pad out", 32'(mio_core_out_i), 32'(mio_pad_out_o));
      compare("mio pad oe", 32'(mio_core_oe_i), 32'(mio_pad_oe_o));
      compare("dio pad out", 32'(dio_core_out_i), 32'(dio_pad_out_o));
      compare("dio pad oe", 32'(dio_core_oe_i), 32'(dio_pad_oe_o));
      wait_edges(Rise, SyncStages);
      compare("mio core in", 32'(mio_pad_in_i), 32'(mio_core_in_o));
      compare("dio core in", 32'(dio_pad_in_i), 32'(dio_core_in_o));
    end
    end_test();
  endtask

  task automatic test_jtag_overlay();
    logic [io_overlay_pkg::NumDio-1:0] exp_in;
    begin_test("jtag_overlay");
    quiet_inputs();
    for (int i = 0; i < 2; i++) begin
      wait_edges(Fall, 1);
      mio_core_out_i = rand_mio();
      mio_core_oe_i  = rand_mio();
      dio_core_out_i = rand_dio();
      dio_core_oe_i  = rand_dio() & ~FlipMask;
      jtag_tdo_i     = i[0];
      mio_pad_in_i   = (rand_mio() & ~UphyMask) | JtagEnMask;
      dio_pad_in_i   = rand_dio();
      wait_edges(Rise, SyncStages + 1);
      compare("jtag port",
              32'({dio_pad_in_i[io_overlay_pkg::DioSpiSck], dio_pad_in_i[io_overlay_pkg::DioSpiCsb],
                   dio_pad_in_i[io_overlay_pkg::DioSpiSd0],
                   mio_pad_in_i[io_overlay_pkg::MioJtagTrst],
                   mio_pad_in_i[io_overlay_pkg::MioJtagSrst]}),
              32'({jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_trst_n_o, jtag_srst_n_o}));
      compare("tdo on sd1", 32'({jtag_tdo_i, 1'b1}),
              32'({dio_pad_out_o[io_overlay_pkg::DioSpiSd1],
                   dio_pad_oe_o[io_overlay_pkg::DioSpiSd1]}));
      // Only SD1 of the borrowed pads is enabled
      compare("dio pad oe", 32'((dio_core_oe_i & ~OvlMask) | Sd1Mask), 32'(dio_pad_oe_o));
      compare("dio pad out", 32'(dio_core_out_i & ~OvlMask), 32'(dio_pad_out_o & ~OvlMask));
      compare("mio pad oe", 32'(mio_core_oe_i & ~RstMask), 32'(mio_pad_oe_o));
      compare("mio pad out", 32'(mio_core_out_i & ~RstMask), 32'(mio_pad_out_o & ~RstMask));
      // Borrowed pads read low except the idle chip select
      exp_in = dio_pad_in_i;
      exp_in[io_overlay_pkg::DioSpiSck] = 1'b0;
      exp_in[io_overlay_pkg::DioSpiCsb] = 1'b1;
      exp_in[io_overlay_pkg::DioSpiSd0] = 1'b0;
      exp_in[io_overlay_pkg::DioSpiSd1] = 1'b0;
      compare("dio core in", 32'(exp_in), 32'(dio_core_in_o));
      compare("mio core in", 32'(mio_pad_in_i & ~RstMask), 32'(mio_core_in_o));
    end
    end_test();
  endtask

  task automatic test_output_flip();
    logic [io_overlay_pkg::NumDio-1:0] exp_out, exp_oe;
    bit flip;
    begin_test("output_flip");
    quiet_inputs();
    for (int i = 0; i < 6; i++) begin
      flip = (i % 3 != 0); // A few unflipped rounds in between
      wait_edges(Fall, 1);
      dio_core_out_i = rand_dio();
      dio_core_oe_i  = (rand_dio() & ~FlipMask) | (flip ? FlipMask : '0);
      wait_edges(Rise, 1);
      exp_out = dio_core_out_i;
      exp_oe  = dio_core_oe_i;
      if (flip) begin
        exp_out[Dn]   = dio_core_out_i[Dp];
        exp_out[Dp]   = dio_core_out_i[Dn];
        exp_out[D]    = ~dio_core_out_i[D];
        exp_out[DnPu] = dio_core_out_i[DpPu];
        exp_out[DpPu] = dio_core_out_i[DnPu];
        exp_oe[Dn]    = dio_core_oe_i[Dp];
        exp_oe[Dp]    = dio_core_oe_i[Dn];
        exp_oe[DnPu]  = dio_core_oe_i[DpPu];
        exp_oe[DpPu]  = dio_core_oe_i[DnPu];
      end
      compare("dio pad out", 32'(exp_out), 32'(dio_pad_out_o));
      compare("dio pad oe", 32'(exp_oe), 32'(dio_pad_oe_o));
      compare("phy out",
              32'({exp_out[Dp], exp_out[Dn], ~exp_oe[Dp], exp_out[DpPu] & exp_oe[DpPu]}),
              32'({uphy_dp_tx_o, uphy_dn_tx_o, uphy_oe_n_o, uphy_dppullup_o}));
    end
    end_test();
  endtask

  task automatic test_input_flip();
    logic [io_overlay_pkg::NumDio-1:0] exp_in;
    begin_test("input_flip");
    quiet_inputs();
    for (int i = 0; i < 4; i++) begin
      wait_edges(Fall, 1);
      dio_core_oe_i = FlipMask;
      dio_pad_in_i  = rand_dio();
      wait_edges(Rise, SyncStages + 1);
      exp_in     = dio_pad_in_i;
      exp_in[Dn] = dio_pad_in_i[Dp];
      exp_in[Dp] = dio_pad_in_i[Dn];
      exp_in[D]  = ~dio_pad_in_i[D];
      compare("dio core in", 32'(exp_in), 32'(dio_core_in_o));
    end
    end_test();
  endtask

  task automatic test_uphy_select();
    logic [31:0] r;
    logic [io_overlay_pkg::NumDio-1:0] exp_in;
    bit flip;
    begin_test("uphy_select");
    quiet_inputs();
    for (int i = 0; i < 6; i++) begin
      flip = i[0];
      wait_edges(Fall, 1);
      r             = next_rand();
      mio_pad_in_i  = UphyMask;
      dio_pad_in_i  = rand_dio(); // PHY lines must win over these
      dio_core_oe_i = flip ? FlipMask : '0;
      {uphy_dp_rx_i, uphy_dn_rx_i, uphy_d_rx_i, uphy_sense_i} = r[31:28];
      wait_edges(Rise, SyncStages + 1);
      exp_in = dio_pad_in_i;
      exp_in[io_overlay_pkg::DioUsbSense] = uphy_sense_i;
      exp_in[Dn] = flip ? uphy_dp_rx_i : uphy_dn_rx_i;
      exp_in[Dp] = flip ? uphy_dn_rx_i : uphy_dp_rx_i;
      exp_in[D]  = uphy_d_rx_i ^ flip;
      compare("dio core in", 32'(exp_in), 32'(dio_core_in_o));
    end
    end_test();
  endtask

//--- verif/io_overlay_tb.sv
/* Testbench for the board I/O overlay. Runs the directed tests of the
   included test file and prints one line per test and the final counts */

`timescale 1ns/1ps

module io_overlay_tb;

  localparam int SyncStages  = 2;
  localparam int ClkHalfNs   = 5; // 10 ns period
  localparam int ResetCycles = 4;
  localparam int TimeoutNs   = 500; // Per wait loop
  localparam logic [31:0] Seed = 32'd46773;
  localparam bit Rise = 1'b0;
  localparam bit Fall = 1'b1;

  // USB pad positions
  localparam int Dn   = io_overlay_pkg::DioUsbDn;
  localparam int Dp   = io_overlay_pkg::DioUsbDp;
  localparam int D    = io_overlay_pkg::DioUsbD;
  localparam int DnPu = io_overlay_pkg::DioUsbDnPullup;
  localparam int DpPu = io_overlay_pkg::DioUsbDpPullup;

  localparam logic [io_overlay_pkg::NumDio-1:0] FlipMask = io_overlay_pkg::NumDio'(1 << DnPu);
  localparam logic [io_overlay_pkg::NumDio-1:0] Sd1Mask =
      io_overlay_pkg::NumDio'(1 << io_overlay_pkg::DioSpiSd1);
  // SPI device pads lent to JTAG
  localparam logic [io_overlay_pkg::NumDio-1:0] OvlMask = Sd1Mask |
      io_overlay_pkg::NumDio'((1 << io_overlay_pkg::DioSpiSd0) |
                              (1 << io_overlay_pkg::DioSpiCsb) |
                              (1 << io_overlay_pkg::DioSpiSck));
  localparam logic [io_overlay_pkg::NumMio-1:0] RstMask =
      io_overlay_pkg::NumMio'((1 << io_overlay_pkg::MioJtagTrst) |
                              (1 << io_overlay_pkg::MioJtagSrst));
  localparam logic [io_overlay_pkg::NumMio-1:0] JtagEnMask =
      io_overlay_pkg::NumMio'(1 << io_overlay_pkg::MioJtagEn);
  localparam logic [io_overlay_pkg::NumMio-1:0] UphyMask =
      io_overlay_pkg::NumMio'(1 << io_overlay_pkg::MioUphySel);

  logic clk_main_i, arst_n_i;
  logic [io_overlay_pkg::NumMio-1:0] mio_pad_in_i, mio_pad_out_o, mio_pad_oe_o;
  logic [io_overlay_pkg::NumMio-1:0] mio_core_out_i, mio_core_oe_i, mio_core_in_o;
  logic [io_overlay_pkg::NumDio-1:0] dio_pad_in_i, dio_pad_out_o, dio_pad_oe_o;
  logic [io_overlay_pkg::NumDio-1:0] dio_core_out_i, dio_core_oe_i, dio_core_in_o;
  logic jtag_tdo_i, jtag_tck_o, jtag_tms_o, jtag_tdi_o, jtag_trst_n_o, jtag_srst_n_o;
  logic uphy_dp_rx_i, uphy_dn_rx_i, uphy_d_rx_i, uphy_sense_i;
  logic uphy_dp_tx_o, uphy_dn_tx_o, uphy_oe_n_o, uphy_dppullup_o;

  logic [31:0] lcg_state;
  int rise_cnt, fall_cnt;
  int tests_run, tests_bad, errors, errors_at_start;
  bit timed_out;
  string test_name;

  io_overlay_top #(
    .SyncStages     (SyncStages),
    .JtagEnPolarity (1'b1)
  ) i_io_overlay_top (.*);

  initial clk_main_i = 1'b0;
  always #ClkHalfNs clk_main_i = ~clk_main_i;
  always @(posedge clk_main_i) rise_cnt <= rise_cnt + 1;
  always @(negedge clk_main_i) fall_cnt <= fall_cnt + 1;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Upper LCG bits, the low ones repeat too soon
  function automatic logic [io_overlay_pkg::NumMio-1:0] rand_mio();
    logic [31:0] r;
    r = next_rand();
    return r[31 -: io_overlay_pkg::NumMio];
  endfunction

  function automatic logic [io_overlay_pkg::NumDio-1:0] rand_dio();
    logic [31:0] r;
    r = next_rand();
    return r[31 -: io_overlay_pkg::NumDio];
  endfunction

  // Polls the edge counters, gives up after TimeoutNs
  task automatic wait_edges(input bit falling, input int n);
    int start;
    int waited;
    start  = falling ? fall_cnt : rise_cnt;
    waited = 0;
    while ((falling ? fall_cnt : rise_cnt) - start < n && waited < TimeoutNs) begin
      #1;
      waited++;
    end
    if ((falling ? fall_cnt : rise_cnt) - start < n) begin
      timed_out = 1'b1;
      $display("Timeout: clock edges missing for %0d ns in %s", TimeoutNs, test_name);
    end
  endtask

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != errors_at_start) begin
      tests_bad++;
      $display("FAIL %s", test_name);
    end else begin
      $display("PASS %s", test_name);
    end
  endtask

  `include "io_overlay_tests.svh"

  initial begin
    lcg_state      = Seed;
    arst_n_i       = 1'b0;
    mio_pad_in_i   = '1; // Pads high through reset
    dio_pad_in_i   = '1;
    mio_core_out_i = '0;
    mio_core_oe_i  = '0;
    dio_core_out_i = '0;
    dio_core_oe_i  = '0;
    jtag_tdo_i     = 1'b0;
    {uphy_dp_rx_i, uphy_dn_rx_i, uphy_d_rx_i, uphy_sense_i} = 4'hf;
    #0.5; // Polling stays off the clock edges
    test_reset_state();
    test_pass_through();
    test_jtag_overlay();
    test_output_flip();
    test_input_flip();
    test_uphy_select();
    $display("Summary: %0d tests, %0d with errors, %0d check errors", tests_run, tests_bad,
             errors);
    if (errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
verilog/io_overlay_pkg.sv
verilog/pad_in_sync.sv
verilog/jtag_overlay_mux.sv
verilog/usb_pinflip_mux.sv
verilog/io_overlay_top.sv
verif/io_overlay_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the I/O overlay testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/1ps -f compile.f \
  --top-module io_overlay_tb -Mdir "$OBJ" -o sim_io_overlay
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$OBJ/sim_io_overlay" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
